//--- hw/trace_cfg_pkg.sv
// trace configuration package: record field widths, trace store depth and counter sizes
package trace_cfg_pkg;

    //////////////////////////////
    // record fields
    //////////////////////////////

    // raw instruction word as fetched
    localparam int instr_w = 32;

    // sequence number, wraps
    localparam int seq_w = 8;

    // free running cycle counter, wraps
    localparam int cyc_w = 16;

    // stalled cycles per instruction, saturates at all ones
    localparam int stall_w = 4;

    //////////////////////////////
    // trace store
    //////////////////////////////

    // records held in the circular memory
    localparam int trace_depth = 8;

    // read and write pointers, wrap naturally at depth
    localparam int addr_w = 3;

    // fill count needs one extra bit to hold 0 to depth
    localparam int count_w = 4;

    // dropped record counter, saturates
    localparam int drop_w = 8;

endpackage

//--- hw/pipe_pkg.sv
// pipeline package: stage names, operation classes, opcode decode and trace control states
package pipe_pkg;

    //////////////////////////////
    // pipeline
    //////////////////////////////

    // five in-order stages, also the tracker slot index
    typedef enum logic [2:0] {
        if_s  = 3'd0,
        id_s  = 3'd1,
        ex_s  = 3'd2,
        mem_s = 3'd3,
        wb_s  = 3'd4
    } stage_e;

    // coarse class of an RV32 base opcode
    typedef enum logic [2:0] {
        cls_alu,
        cls_alu_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,
        cls_upper,
        cls_other
    } op_class_e;

    //////////////////////////////
    // trace store access
    //////////////////////////////

    // who owns the memory port this cycle
    typedef enum logic [1:0] {gnt_none, gnt_write, gnt_read} arb_grant_e;

    // host read sequencing
    typedef enum logic [1:0] {rd_idle, rd_wait, rd_data} rd_state_e;

    // low seven instruction bits to class
    function automatic op_class_e decode_class(input logic [6:0] opcode);
        op_class_e cls;
        case (opcode)
            7'b0110011: cls = cls_alu;
            7'b0010011: cls = cls_alu_imm;
            7'b0000011: cls = cls_load;
            7'b0100011: cls = cls_store;
            7'b1100011: cls = cls_branch;
            // jal and jalr
            7'b1101111, 7'b1100111: cls = cls_jump;
            // lui and auipc
            7'b0110111, 7'b0010111: cls = cls_upper;
            default: cls = cls_other;
        endcase
        return cls;
    endfunction

endpackage

//--- hw/stage_tracker.sv
// stage tracker: numbers each fetch, follows it through five slots and emits the retired record
module stage_tracker
    import trace_cfg_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  logic [instr_w-1:0] fetch_instr,
    input  logic               stall,
    input  logic               flush,
    output logic               retire,
    output logic [seq_w-1:0]   ret_seq,
    output logic [instr_w-1:0] ret_instr,
    output op_class_e          ret_class,
    output logic [cyc_w-1:0]   ret_fetch_cycle,
    output logic [cyc_w-1:0]   ret_retire_cycle,
    output logic [stall_w-1:0] ret_stall_cycles
);

    // free running cycle count and next number to hand out
    logic [cyc_w-1:0] cycle;
    logic [seq_w-1:0] next_seq;

    // per slot state, indexed by stage_e
    logic               slot_valid  [5];
    logic [seq_w-1:0]   slot_seq    [5];
    logic [instr_w-1:0] slot_instr  [5];
    logic [cyc_w-1:0]   slot_fcyc   [5];
    logic [stall_w-1:0] slot_stalls [5];
    op_class_e          slot_class  [5];

    // cycle at which the wb slot was loaded
    logic [cyc_w-1:0] wb_cycle;

    // front half held, flush overrides stall
    logic hold;
    logic accept;

    assign hold   = stall && !flush;
    assign accept = fetch_valid && !hold;

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle      <= '0;
            next_seq   <= '0;
            slot_valid <= '{default: 1'b0};
        end else begin
            cycle <= cycle + 1'b1;
            if (accept) begin
                next_seq <= next_seq + 1'b1;
            end
            // back half never stops
            slot_valid[wb_s]  <= slot_valid[mem_s];
            slot_valid[mem_s] <= slot_valid[ex_s];
            if (flush) begin
                // if and id emptied, new fetch still enters
                slot_valid[ex_s] <= 1'b0;
                slot_valid[id_s] <= 1'b0;
                slot_valid[if_s] <= accept;
            end else if (hold) begin
                // bubble into ex, front slots keep their valid
                slot_valid[ex_s] <= 1'b0;
            end else begin
                slot_valid[ex_s] <= slot_valid[id_s];
                slot_valid[id_s] <= slot_valid[if_s];
                slot_valid[if_s] <= accept;
            end
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        // ex to mem, mem to wb
        for (int s = mem_s; s <= wb_s; s++) begin
            slot_seq[s]    <= slot_seq[s-1];
            slot_instr[s]  <= slot_instr[s-1];
            slot_fcyc[s]   <= slot_fcyc[s-1];
            slot_stalls[s] <= slot_stalls[s-1];
            slot_class[s]  <= slot_class[s-1];
        end
        wb_cycle <= cycle;
        if (hold) begin
            // each held valid slot counts the lost cycle
            if (slot_valid[if_s] && slot_stalls[if_s] != '1) begin
                slot_stalls[if_s] <= slot_stalls[if_s] + 1'b1;
            end
            if (slot_valid[id_s] && slot_stalls[id_s] != '1) begin
                slot_stalls[id_s] <= slot_stalls[id_s] + 1'b1;
            end
        end else begin
            slot_seq[ex_s]    <= slot_seq[id_s];
            slot_instr[ex_s]  <= slot_instr[id_s];
            slot_fcyc[ex_s]   <= slot_fcyc[id_s];
            slot_stalls[ex_s] <= slot_stalls[id_s];
            slot_class[ex_s]  <= slot_class[id_s];
            // class resolved on entry to decode
            slot_seq[id_s]    <= slot_seq[if_s];
            slot_instr[id_s]  <= slot_instr[if_s];
            slot_fcyc[id_s]   <= slot_fcyc[if_s];
            slot_stalls[id_s] <= slot_stalls[if_s];
            slot_class[id_s]  <= decode_class(slot_instr[if_s][6:0]);
            // fresh fetch, stamped with this edge's cycle
            slot_seq[if_s]    <= next_seq;
            slot_instr[if_s]  <= fetch_instr;
            slot_fcyc[if_s]   <= cycle;
            slot_stalls[if_s] <= '0;
        end
    end

    // wb slot is the retire record
    assign retire           = slot_valid[wb_s];
    assign ret_seq          = slot_seq[wb_s];
    assign ret_instr        = slot_instr[wb_s];
    assign ret_class        = slot_class[wb_s];
    assign ret_fetch_cycle  = slot_fcyc[wb_s];
    assign ret_retire_cycle = wb_cycle;
    assign ret_stall_cycles = slot_stalls[wb_s];

endmodule

//--- hw/retire_writer.sv
// retire writer: latches each retired record and writes it to the trace store or counts a drop
module retire_writer
    import trace_cfg_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               retire,
    input  logic [seq_w-1:0]   ret_seq,
    input  logic [instr_w-1:0] ret_instr,
    input  op_class_e          ret_class,
    input  logic [cyc_w-1:0]   ret_fetch_cycle,
    input  logic [cyc_w-1:0]   ret_retire_cycle,
    input  logic [stall_w-1:0] ret_stall_cycles,
    input  logic               wr_gnt,
    input  logic               full,
    output logic               wr_req,
    output logic [seq_w-1:0]   wr_seq,
    output logic [instr_w-1:0] wr_instr,
    output op_class_e          wr_class,
    output logic [cyc_w-1:0]   wr_fetch_cycle,
    output logic [cyc_w-1:0]   wr_retire_cycle,
    output logic [stall_w-1:0] wr_stall_cycles,
    output logic [drop_w-1:0]  drop_count
);

    // one record in flight at most
    logic held;

    always_ff @(posedge clk) begin
        if (rst) begin
            held       <= 1'b0;
            drop_count <= '0;
        end else begin
            held <= retire;
            // held record not taken, store was full
            if (held && !wr_gnt && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            wr_seq          <= ret_seq;
            wr_instr        <= ret_instr;
            wr_class        <= ret_class;
            wr_fetch_cycle  <= ret_fetch_cycle;
            wr_retire_cycle <= ret_retire_cycle;
            wr_stall_cycles <= ret_stall_cycles;
        end
    end

    // write wins arbitration, so only fullness blocks it
    assign wr_req = held && !full;

endmodule

//--- hw/trace_reader.sv
// trace reader: turns a host read pulse into one store read and returns the oldest record
module trace_reader
    import trace_cfg_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_req,
    input  logic               rd_mem_gnt,
    input  logic [count_w-1:0] count,
    input  logic [seq_w-1:0]   mem_seq,
    input  logic [instr_w-1:0] mem_instr,
    input  op_class_e          mem_class,
    input  logic [cyc_w-1:0]   mem_fetch_cycle,
    input  logic [cyc_w-1:0]   mem_retire_cycle,
    input  logic [stall_w-1:0] mem_stall_cycles,
    output logic               rd_mem_req,
    output logic               busy,
    output logic               rd_valid,
    output logic               rd_empty_hit,
    output logic [seq_w-1:0]   rd_seq,
    output logic [instr_w-1:0] rd_instr,
    output op_class_e          rd_class,
    output logic [cyc_w-1:0]   rd_fetch_cycle,
    output logic [cyc_w-1:0]   rd_retire_cycle,
    output logic [stall_w-1:0] rd_stall_cycles
);

    rd_state_e state;
    // store was empty when the request came in
    logic empty_q;
    logic rec_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= rd_idle;
            empty_q <= 1'b0;
        end else begin
            case (state)
                rd_idle: if (rd_req) begin
                    state   <= rd_wait;
                    empty_q <= (count == '0);
                end
                // empty requests skip the store but keep the same latency
                rd_wait: if (rd_mem_gnt || empty_q) begin
                    state <= rd_data;
                end
                rd_data: state <= rd_idle;
                default: state <= rd_idle;
            endcase
        end
    end

    assign rd_mem_req   = (state == rd_wait) && !empty_q;
    assign busy         = (state != rd_idle);
    assign rd_valid     = (state == rd_data);
    assign rd_empty_hit = rd_valid && empty_q;

    // store data lands the cycle after grant, zero on empty
    assign rec_ok          = rd_valid && !empty_q;
    assign rd_seq          = rec_ok ? mem_seq : '0;
    assign rd_instr        = rec_ok ? mem_instr : '0;
    assign rd_class        = rec_ok ? mem_class : op_class_e'(0);
    assign rd_fetch_cycle  = rec_ok ? mem_fetch_cycle : '0;
    assign rd_retire_cycle = rec_ok ? mem_retire_cycle : '0;
    assign rd_stall_cycles = rec_ok ? mem_stall_cycles : '0;

endmodule

//--- hw/trace_store.sv
// trace store: circular single-port record memory with write-priority arbitration
module trace_store
    import trace_cfg_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_req,
    input  logic [seq_w-1:0]   wr_seq,
    input  logic [instr_w-1:0] wr_instr,
    input  op_class_e          wr_class,
    input  logic [cyc_w-1:0]   wr_fetch_cycle,
    input  logic [cyc_w-1:0]   wr_retire_cycle,
    input  logic [stall_w-1:0] wr_stall_cycles,
    input  logic               rd_mem_req,
    output logic               wr_gnt,
    output logic               rd_mem_gnt,
    output logic               full,
    output logic [count_w-1:0] count,
    output logic [seq_w-1:0]   mem_seq,
    output logic [instr_w-1:0] mem_instr,
    output op_class_e          mem_class,
    output logic [cyc_w-1:0]   mem_fetch_cycle,
    output logic [cyc_w-1:0]   mem_retire_cycle,
    output logic [stall_w-1:0] mem_stall_cycles
);

    // one array per record field
    logic [seq_w-1:0]   seq_ram    [trace_depth];
    logic [instr_w-1:0] instr_ram  [trace_depth];
    op_class_e          class_ram  [trace_depth];
    logic [cyc_w-1:0]   fcyc_ram   [trace_depth];
    logic [cyc_w-1:0]   rcyc_ram   [trace_depth];
    logic [stall_w-1:0] stalls_ram [trace_depth];

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    arb_grant_e        grant;

    //////////////////////////////
    // arbiter
    //////////////////////////////

    // write first, read only on an idle port
    always_comb begin
        grant = gnt_none;
        if (wr_req && !full) begin
            grant = gnt_write;
        end else if (rd_mem_req) begin
            grant = gnt_read;
        end
    end

    assign wr_gnt     = (grant == gnt_write);
    assign rd_mem_gnt = (grant == gnt_read);
    assign full       = (count == count_w'(trace_depth));

    // pointers wrap at depth, grants are exclusive
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_gnt) begin
                wr_ptr <= wr_ptr + 1'b1;
                count  <= count + 1'b1;
            end else if (rd_mem_gnt) begin
                rd_ptr <= rd_ptr + 1'b1;
                count  <= count - 1'b1;
            end
        end
    end

    //////////////////////////////
    // memory port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            seq_ram[wr_ptr]    <= wr_seq;
            instr_ram[wr_ptr]  <= wr_instr;
            class_ram[wr_ptr]  <= wr_class;
            fcyc_ram[wr_ptr]   <= wr_fetch_cycle;
            rcyc_ram[wr_ptr]   <= wr_retire_cycle;
            stalls_ram[wr_ptr] <= wr_stall_cycles;
        end
        // oldest record out, one cycle after grant
        if (rd_mem_gnt) begin
            mem_seq          <= seq_ram[rd_ptr];
            mem_instr        <= instr_ram[rd_ptr];
            mem_class        <= class_ram[rd_ptr];
            mem_fetch_cycle  <= fcyc_ram[rd_ptr];
            mem_retire_cycle <= rcyc_ram[rd_ptr];
            mem_stall_cycles <= stalls_ram[rd_ptr];
        end
    end

endmodule

//--- hw/pipe_trace_top.sv
// pipeline retirement tracer top: tracker, writer, trace store and host reader
module pipe_trace_top
    import trace_cfg_pkg::*, pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  logic [instr_w-1:0] fetch_instr,
    input  logic               stall,
    input  logic               flush,
    input  logic               rd_req,
    output logic               busy,
    output logic               rd_valid,
    output logic               rd_empty_hit,
    output logic [seq_w-1:0]   rd_seq,
    output logic [instr_w-1:0] rd_instr,
    output op_class_e          rd_class,
    output logic [cyc_w-1:0]   rd_fetch_cycle,
    output logic [cyc_w-1:0]   rd_retire_cycle,
    output logic [stall_w-1:0] rd_stall_cycles,
    output logic [count_w-1:0] trace_count,
    output logic [drop_w-1:0]  drop_count
);

    // tracker to writer
    logic               retire;
    logic [seq_w-1:0]   ret_seq;
    logic [instr_w-1:0] ret_instr;
    op_class_e          ret_class;
    logic [cyc_w-1:0]   ret_fetch_cycle, ret_retire_cycle;
    logic [stall_w-1:0] ret_stall_cycles;

    // writer to store
    logic               wr_req, wr_gnt, full;
    logic [seq_w-1:0]   wr_seq;
    logic [instr_w-1:0] wr_instr;
    op_class_e          wr_class;
    logic [cyc_w-1:0]   wr_fetch_cycle, wr_retire_cycle;
    logic [stall_w-1:0] wr_stall_cycles;

    // store to reader
    logic               rd_mem_req, rd_mem_gnt;
    logic [seq_w-1:0]   mem_seq;
    logic [instr_w-1:0] mem_instr;
    op_class_e          mem_class;
    logic [cyc_w-1:0]   mem_fetch_cycle, mem_retire_cycle;
    logic [stall_w-1:0] mem_stall_cycles;

    stage_tracker stage_tracker_i (.*);

    retire_writer retire_writer_i (.*);

    trace_reader trace_reader_i (
        .count (trace_count),
        .*
    );

    trace_store trace_store_i (
        .count (trace_count),
        .*
    );

endmodule

//--- verification/pipe_trace_tb.sv
// testbench for the pipeline retirement tracer: random pipeline traffic against a slot model
module pipe_trace_tb
    import trace_cfg_pkg::*, pipe_pkg::*;
();

    // retired record as the model sees it
    // class is decoded only at compare time
    typedef struct packed {
        logic [seq_w-1:0]   seq;
        logic [instr_w-1:0] instr;
        logic [cyc_w-1:0]   fcyc;
        logic [cyc_w-1:0]   rcyc;
        logic [stall_w-1:0] stalls;
    } rec_t;

    logic               clk;
    logic               rst;
    logic               fetch_valid;
    logic [instr_w-1:0] fetch_instr;
    logic               stall;
    logic               flush;
    logic               rd_req;
    logic               busy;
    logic               rd_valid;
    logic               rd_empty_hit;
    logic [seq_w-1:0]   rd_seq;
    logic [instr_w-1:0] rd_instr;
    op_class_e          rd_class;
    logic [cyc_w-1:0]   rd_fetch_cycle;
    logic [cyc_w-1:0]   rd_retire_cycle;
    logic [stall_w-1:0] rd_stall_cycles;
    logic [count_w-1:0] trace_count;
    logic [drop_w-1:0]  drop_count;

    // reference pipeline with slots indexed by stage_e
    logic              m_valid [5];
    rec_t              m_rec [5];
    logic              m_held;
    rec_t              m_held_rec;
    logic [cyc_w-1:0]  m_cycle;
    logic [seq_w-1:0]  m_next_seq;
    logic [drop_w-1:0] m_drops;
    int                m_accepted;
    // expected store contents with the oldest first
    rec_t              store_q [$];

    // scoreboard and stimulus state
    logic        req_empty;
    logic [31:0] rng;
    int          op_idx = 0;
    int          rec_reads = 0;
    int          read_mark = 0;
    int          checks = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;

    // one opcode per RV32 group
    // fence and system fall into the other class
    logic [6:0] op_tab [11] = '{
        7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
        7'b1100111, 7'b0110111, 7'b0010111, 7'b0001111, 7'b1110011
    };

    pipe_trace_top pipe_trace_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic void reset_model();
        for (int s = 0; s < 5; s++) begin
            m_valid[s] = 1'b0;
            m_rec[s] = '0;
        end
        m_held = 1'b0;
        m_held_rec = '0;
        m_cycle = '0;
        m_next_seq = '0;
        m_drops = '0;
        m_accepted = 0;
        store_q.delete();
    endfunction

    // one clock edge of tracker, writer and store fill
    function automatic void step_model(input logic fv, input logic [instr_w-1:0] instr,
                                       input logic st, input logic fl);
        logic hold;
        logic accept;
        rec_t fresh;
        hold = st && !fl;
        accept = fv && !hold;
        // record retired last cycle lands now or is lost on a full store
        if (m_held) begin
            if (store_q.size() < trace_depth) begin
                store_q.push_back(m_held_rec);
            end else if (m_drops != '1) begin
                m_drops = m_drops + 1'b1;
            end
        end
        m_held = m_valid[wb_s];
        m_held_rec = m_rec[wb_s];
        // back half always moves
        m_valid[wb_s] = m_valid[mem_s];
        m_rec[wb_s] = m_rec[mem_s];
        m_rec[wb_s].rcyc = m_cycle;
        m_valid[mem_s] = m_valid[ex_s];
        m_rec[mem_s] = m_rec[ex_s];
        fresh = '0;
        fresh.seq = m_next_seq;
        fresh.instr = instr;
        fresh.fcyc = m_cycle;
        if (fl) begin
            // front half squashed but the new fetch still enters
            m_valid[ex_s] = 1'b0;
            m_valid[id_s] = 1'b0;
            m_valid[if_s] = accept;
            m_rec[if_s] = fresh;
        end else if (hold) begin
            m_valid[ex_s] = 1'b0;
            if (m_valid[if_s] && m_rec[if_s].stalls != '1) begin
                m_rec[if_s].stalls = m_rec[if_s].stalls + 1'b1;
            end
            if (m_valid[id_s] && m_rec[id_s].stalls != '1) begin
                m_rec[id_s].stalls = m_rec[id_s].stalls + 1'b1;
            end
        end else begin
            m_valid[ex_s] = m_valid[id_s];
            m_rec[ex_s] = m_rec[id_s];
            m_valid[id_s] = m_valid[if_s];
            m_rec[id_s] = m_rec[if_s];
            m_valid[if_s] = accept;
            m_rec[if_s] = fresh;
        end
        if (accept) begin
            m_next_seq = m_next_seq + 1'b1;
            m_accepted++;
        end
        m_cycle = m_cycle + 1'b1;
    endfunction

    function automatic bit pipeline_drained();
        return !m_held && !m_valid[if_s] && !m_valid[id_s] && !m_valid[ex_s]
            && !m_valid[mem_s] && !m_valid[wb_s];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            reset_model();
        end else begin
            step_model(fetch_valid, fetch_instr, stall, flush);
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        compare_field(name, 32'(got), 32'(want));
    endtask

    task automatic check_record(
        input logic [seq_w-1:0]   got_seq,
        input logic [instr_w-1:0] got_instr,
        input op_class_e          got_class,
        input logic [cyc_w-1:0]   got_fcyc,
        input logic [cyc_w-1:0]   got_rcyc,
        input logic [stall_w-1:0] got_stalls,
        input rec_t               want,
        input op_class_e          want_class
    );
        compare_field("rd_seq", 32'(got_seq), 32'(want.seq));
        compare_field("rd_instr", got_instr, want.instr);
        compare_field("rd_fetch_cycle", 32'(got_fcyc), 32'(want.fcyc));
        compare_field("rd_retire_cycle", 32'(got_rcyc), 32'(want.rcyc));
        compare_field("rd_stall_cycles", 32'(got_stalls), 32'(want.stalls));
        checks++;
        if (got_class !== want_class) begin
            errors++;
            $display("[FAIL] rd_class got 0x%h expected 0x%h", got_class, want_class);
        end
    endtask

    task automatic check_count(input logic [count_w-1:0] got_count,
                               input logic [count_w-1:0] want_count,
                               input logic [drop_w-1:0]  got_drop,
                               input logic [drop_w-1:0]  want_drop);
        compare_field("trace_count", 32'(got_count), 32'(want_count));
        compare_field("drop_count", 32'(got_drop), 32'(want_drop));
    endtask

    // every finished read is checked against the oldest expected record
    always @(negedge clk) begin
        rec_t want;
        if (!rst && rd_valid) begin
            check_flag("rd_empty_hit", rd_empty_hit, req_empty);
            if (req_empty) begin
                want = '0;
                check_record(rd_seq, rd_instr, rd_class, rd_fetch_cycle, rd_retire_cycle,
                             rd_stall_cycles, want, op_class_e'(0));
            end else if (store_q.size() == 0) begin
                errors++;
                $display("read returned a record although none was expected");
            end else begin
                want = store_q.pop_front();
                check_record(rd_seq, rd_instr, rd_class, rd_fetch_cycle, rd_retire_cycle,
                             rd_stall_cycles, want, decode_class(want.instr[6:0]));
                rec_reads++;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [instr_w-1:0] make_instr(input bit walk_ops);
        logic [31:0] r;
        int idx;
        r = next_rand();
        if (walk_ops) begin
            idx = op_idx % 11;
            op_idx++;
        end else begin
            idx = int'(r[31:28]) % 11;
        end
        return {r[31:7], op_tab[idx]};
    endfunction

    task automatic stop_run(input string what);
        $display("timeout while waiting for %s", what);
        $display(">>> FAIL");
        $finish;
    endtask

    // random traffic until n more fetches were accepted
    task automatic drive_burst(input int n_accept, input int fetch_pct, input int stall_pct,
                               input int flush_pct, input bit walk_ops);
        int start;
        int cycles;
        start = m_accepted;
        cycles = 0;
        forever begin
            @(negedge clk);
            if (m_accepted - start >= n_accept) begin
                break;
            end
            if (cycles == 400) begin
                stop_run("fetches to be accepted");
            end
            cycles++;
            fetch_valid = (next_rand() % 100) < fetch_pct;
            stall = (next_rand() % 100) < stall_pct;
            flush = (next_rand() % 100) < flush_pct;
            fetch_instr = make_instr(walk_ops);
        end
        fetch_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!pipeline_drained()) begin
            if (waited == 30) begin
                stop_run("the pipeline to drain");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // one host read whose answer the compare process checks
    task automatic read_one();
        int waited;
        waited = 0;
        while (busy) begin
            if (waited == 20) begin
                stop_run("the reader to go idle");
            end
            @(negedge clk);
            waited++;
        end
        req_empty = (store_q.size() == 0);
        rd_req = 1'b1;
        @(negedge clk);
        rd_req = 1'b0;
        // accepted request keeps the reader busy
        check_flag("busy", busy, 1'b1);
        waited = 0;
        while (!rd_valid) begin
            if (waited == 40) begin
                stop_run("rd_valid");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        // reader free again after the data cycle
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic read_back_all();
        int guard;
        guard = 0;
        while (store_q.size() != 0) begin
            if (guard == 20) begin
                stop_run("the store to empty");
            end
            read_one();
            guard++;
        end
        // one more read must hit an empty store
        read_one();
    endtask

    task automatic close_test(input string name);
        wait_drain();
        read_back_all();
        check_count(trace_count, count_w'(store_q.size()), drop_count, m_drops);
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, errors - err_mark);
        err_mark = errors;
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        rd_req = 1'b0;
        req_empty = 1'b0;
        rng = 32'habb4ccad;
        // two rising edges in reset, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // gaps in fetch only
        drive_burst(8, 70, 0, 0, 1'b0);
        close_test("straight_line");

        drive_burst(8, 80, 35, 0, 1'b0);
        close_test("stall");

        drive_burst(8, 80, 20, 20, 1'b0);
        close_test("flush");

        // 12 fetches walk all 11 table entries
        drive_burst(6, 100, 0, 0, 1'b1);
        wait_drain();
        read_back_all();
        drive_burst(6, 100, 0, 0, 1'b1);
        close_test("class_decode");

        // 12 retirements into 8 slots with no reads
        drive_burst(12, 100, 0, 0, 1'b0);
        wait_drain();
        check_count(trace_count, count_w'(trace_depth), drop_count, drop_w'(12 - trace_depth));
        close_test("overflow");

        // host reads race the writer for the store port
        read_mark = rec_reads;
        fork
            drive_burst(6, 60, 25, 0, 1'b0);
            begin
                int tries;
                tries = 0;
                while (rec_reads - read_mark < 6 && tries < 40) begin
                    read_one();
                    tries++;
                end
                if (rec_reads - read_mark < 6) begin
                    errors++;
                    $display("reads during retirement returned only %0d of 6 records",
                             rec_reads - read_mark);
                end
            end
        join
        close_test("read_during_retire");

        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/trace_cfg_pkg.sv
hw/pipe_pkg.sv
hw/stage_tracker.sv
hw/retire_writer.sv
hw/trace_reader.sv
hw/trace_store.sv
hw/pipe_trace_top.sv
verification/pipe_trace_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module pipe_trace_tb -o pipe_trace_sim

out=$(./obj_dir/pipe_trace_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
